/* frame_buffer_top.f */
+incdir+.
fbuf_pkg.sv
fbuf_if.sv
dpram_s8_s16.sv
byte_loader.sv
word_streamer.sv
word_checksum.sv
frame_ctrl.sv
frame_buffer_top.sv
tb_frame_buffer.sv

/* Bender.yml */
package:
  name: frame_buffer

export_include_dirs:
  - .

sources:
  - fbuf_pkg.sv
  - fbuf_if.sv
  - dpram_s8_s16.sv
  - byte_loader.sv
  - word_streamer.sv
  - word_checksum.sv
  - frame_ctrl.sv
  - frame_buffer_top.sv
  - target: test
    files:
      - tb_frame_buffer.sv

/* tb_frame_buffer.sv */
// ------------------------------
// Frame buffer testbench
// ------------------------------
`include "fbuf_params.svh"

module tb_frame_buffer import fbuf_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS  = 7;
  localparam int WAIT_LIMIT = 2000;

  logic                    sys_clk;
  logic                    reset;
  logic                    byte_valid;
  logic [`FBUF_BYTE_W-1:0] byte_data;
  logic                    load_clear;
  logic                    start;
  word_addr_t              base_word;
  count_t                  word_count;
  count_t                  bytes_loaded;
  logic                    full;
  logic                    out_valid;
  word_t                   out_word;
  logic                    busy;
  logic                    done;
  word_t                   checksum;

  // Reference memory with its own pointer and fill count
  logic [7:0] model_mem [`FBUF_BYTE_DEPTH];
  int         model_ptr;
  int         model_fill;

  integer seed;
  string  cur_name;
  int     test_errors;
  int     passed;
  int     failed;
  bit     timed_out;
  word_t  got_words [$];
  word_t  got_sum;

  // ------------------------------
  // Test table
  // ------------------------------
  // Name, bytes to load, clear first, first word, word count
  string t_name  [NUM_TESTS] = '{"fill_all", "partial_scan", "zero_count", "wrap_scan",
                                 "overfill", "clear_reload", "reload_part"};
  int    t_bytes [NUM_TESTS] = '{1024, 0, 0, 0, 20, 6, 300};
  bit    t_clear [NUM_TESTS] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
  int    t_base  [NUM_TESTS] = '{0, 100, 5, 500, 0, 0, 140};
  int    t_count [NUM_TESTS] = '{512, 37, 0, 30, 16, 3, 20};

  initial sys_clk = 1'b0;
  always #4 sys_clk = ~sys_clk;

  frame_buffer_top dut0 (
    .sys_clk      (sys_clk),
    .reset        (reset),
    .byte_valid   (byte_valid),
    .byte_data    (byte_data),
    .load_clear   (load_clear),
    .start        (start),
    .base_word    (base_word),
    .word_count   (word_count),
    .bytes_loaded (bytes_loaded),
    .full         (full),
    .out_valid    (out_valid),
    .out_word     (out_word),
    .busy         (busy),
    .done         (done),
    .checksum     (checksum)
  );

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic check_value(string what, int expected, int actual);
    assert (expected == actual) else begin
      $display("ERROR %s: %s expected 0x%0h actual 0x%0h", cur_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic clear_load();
    @(posedge sys_clk);
    load_clear <= 1'b1;
    @(posedge sys_clk);
    load_clear <= 1'b0;
    model_ptr  = 0;
    model_fill = 0;
    @(negedge sys_clk);
    check_value("bytes_loaded after clear", 0, bytes_loaded);
    check_value("full after clear", 0, full);
  endtask

  task automatic load_bytes(int n);
    logic [7:0] b;
    for (int i = 0; i < n; i++) begin
      b = 8'($random(seed));
      @(posedge sys_clk);
      byte_valid <= 1'b1;
      byte_data  <= b;
      // Bytes past a full memory are dropped
      if (model_fill < `FBUF_BYTE_DEPTH) begin
        model_mem[model_ptr] = b;
        model_ptr  = (model_ptr + 1) % `FBUF_BYTE_DEPTH;
        model_fill++;
      end
    end
    @(posedge sys_clk);
    byte_valid <= 1'b0;
    @(negedge sys_clk);
    check_value("bytes_loaded", model_fill, bytes_loaded);
    check_value("full", model_fill == `FBUF_BYTE_DEPTH, full);
  endtask

  // Start a scan and gather words until done
  task automatic run_scan(int base, int count);
    int cycles;
    bit seen_done;
    bit busy_dropped;
    got_words.delete();
    @(posedge sys_clk);
    start      <= 1'b1;
    base_word  <= word_addr_t'(base);
    word_count <= count_t'(count);
    @(posedge sys_clk);
    start <= 1'b0;
    cycles       = 0;
    seen_done    = 1'b0;
    busy_dropped = 1'b0;
    while (!seen_done && cycles < WAIT_LIMIT) begin
      @(negedge sys_clk);
      cycles++;
      // Busy spans the whole scan up to and including done
      if (busy !== 1'b1) begin
        busy_dropped = 1'b1;
      end
      if (out_valid) begin
        got_words.push_back(out_word);
      end
      // Checksum settles by the done cycle
      if (done) begin
        seen_done = 1'b1;
        got_sum   = checksum;
      end
    end
    if (!seen_done) begin
      $display("TIMEOUT %s: done did not arrive within %0d cycles", cur_name, WAIT_LIMIT);
      timed_out = 1'b1;
      test_errors++;
    end
    check_value("busy during scan", 1, !busy_dropped);
  endtask

  // Odd byte in the high half, even byte in the low half
  task automatic check_words(int base, int count);
    int    w;
    word_t exp_word;
    word_t exp_sum;
    check_value("word count", count, got_words.size());
    exp_sum = '0;
    for (int i = 0; i < count; i++) begin
      w        = (base + i) % `FBUF_WORD_DEPTH;
      exp_word = {model_mem[2*w+1], model_mem[2*w]};
      exp_sum  = exp_sum + exp_word;
      if (i < got_words.size()) begin
        check_value($sformatf("word %0d", i), exp_word, got_words[i]);
      end
    end
    check_value("checksum", exp_sum, got_sum);
  endtask

  task automatic report_test();
    if (test_errors == 0) begin
      passed++;
      $display("PASS %s", cur_name);
    end else begin
      failed++;
      $display("FAIL %s (%0d errors)", cur_name, test_errors);
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    seed        = 69;
    passed      = 0;
    failed      = 0;
    timed_out   = 1'b0;
    model_ptr   = 0;
    model_fill  = 0;
    got_sum     = '0;
    reset       = 1'b1;
    byte_valid  = 1'b0;
    byte_data   = '0;
    load_clear  = 1'b0;
    start       = 1'b0;
    base_word   = '0;
    word_count  = '0;
    repeat (5) @(posedge sys_clk);
    reset <= 1'b0;
    @(negedge sys_clk);

    // Idle outputs out of reset
    cur_name    = "reset_state";
    test_errors = 0;
    check_value("out_valid", 0, out_valid);
    check_value("busy", 0, busy);
    check_value("done", 0, done);
    check_value("full", 0, full);
    check_value("bytes_loaded", 0, bytes_loaded);
    report_test();

    for (int t = 0; t < NUM_TESTS; t++) begin
      cur_name    = t_name[t];
      test_errors = 0;
      if (t_clear[t]) begin
        clear_load();
      end
      load_bytes(t_bytes[t]);
      run_scan(t_base[t], t_count[t]);
      check_words(t_base[t], t_count[t]);
      report_test();
      if (timed_out) begin
        break;
      end
    end

    $display("Tests run: %0d, passed: %0d, failed: %0d", passed + failed, passed, failed);
    if (failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* frame_buffer_top.sv */
// ------------------------------
// Frame buffer top
// ------------------------------
`include "fbuf_params.svh"

module frame_buffer_top import fbuf_pkg::*; (
  input  logic                    sys_clk,
  input  logic                    reset,
  // Byte load side
  input  logic                    byte_valid,
  input  logic [`FBUF_BYTE_W-1:0] byte_data,
  input  logic                    load_clear,
  // Scan request
  input  logic                    start,
  input  word_addr_t              base_word,
  input  count_t                  word_count,
  // Load status
  output count_t                  bytes_loaded,
  output logic                    full,
  // Word stream and scan status
  output logic                    out_valid,
  output word_t                   out_word,
  output logic                    busy,
  output logic                    done,
  output word_t                   checksum
);

  // Port A
  logic                    we_a;
  byte_addr_t              addr_a;
  logic [`FBUF_BYTE_W-1:0] data_a;
  // Port B
  logic                    en_b;
  word_addr_t              addr_b;
  word_t                   q_b;
  logic                    sum_clear;

  scan_if scan_bus ();

  // ------------------------------
  // Memory and load side
  // ------------------------------
  dpram_s8_s16 u_ram (
    .sys_clk (sys_clk),
    .we_a    (we_a),
    .addr_a  (addr_a),
    .data_a  (data_a),
    .q_a     (),
    .en_b    (en_b),
    .addr_b  (addr_b),
    .q_b     (q_b)
  );

  byte_loader u_loader (
    .sys_clk      (sys_clk),
    .reset        (reset),
    .byte_valid   (byte_valid),
    .byte_data    (byte_data),
    .load_clear   (load_clear),
    .we_a         (we_a),
    .addr_a       (addr_a),
    .data_a       (data_a),
    .bytes_loaded (bytes_loaded),
    .full         (full)
  );

  // ------------------------------
  // Scan side
  // ------------------------------
  frame_ctrl u_ctrl (
    .sys_clk    (sys_clk),
    .reset      (reset),
    .start      (start),
    .base_word  (base_word),
    .word_count (word_count),
    .scan       (scan_bus.ctrl),
    .sum_clear  (sum_clear),
    .busy       (busy),
    .done       (done)
  );

  word_streamer u_stream (
    .sys_clk   (sys_clk),
    .reset     (reset),
    .scan      (scan_bus.stream),
    .en_b      (en_b),
    .addr_b    (addr_b),
    .q_b       (q_b),
    .out_valid (out_valid),
    .out_word  (out_word)
  );

  word_checksum u_sum (
    .sys_clk   (sys_clk),
    .reset     (reset),
    .sum_clear (sum_clear),
    .out_valid (out_valid),
    .out_word  (out_word),
    .checksum  (checksum)
  );

endmodule

/* frame_ctrl.sv */
// ------------------------------
// Scan controller
// ------------------------------
`include "fbuf_params.svh"

module frame_ctrl import fbuf_pkg::*; (
  input  logic       sys_clk,
  input  logic       reset,
  // Scan request
  input  logic       start,
  input  word_addr_t base_word,
  input  count_t     word_count,
  // Streamer control
  scan_if.ctrl       scan,
  // Checksum and status
  output logic       sum_clear,
  output logic       busy,
  output logic       done
);

  scan_state_e state_q;
  scan_state_e state_d;
  word_addr_t  base_q;
  count_t      count_q;
  logic        go_q;
  logic        accept;

  // Start only counts when idle
  assign accept = (state_q == SCAN_IDLE) && start;

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      SCAN_IDLE: begin
        if (start) begin
          state_d = SCAN_ISSUE;
        end
      end
      SCAN_ISSUE: begin
        // Empty scan has nothing to wait for
        if (count_q == '0) begin
          state_d = SCAN_DONE;
        end else if (scan.issue_end) begin
          state_d = SCAN_DRAIN;
        end
      end
      SCAN_DRAIN: begin
        if (scan.idle) begin
          state_d = SCAN_DONE;
        end
      end
      default: state_d = SCAN_IDLE;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      state_q <= SCAN_IDLE;
      go_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      // Burst only for a nonzero count
      go_q    <= accept && (word_count != '0);
    end
  end

  // Request held for the streamer to sample on go
  always_ff @(posedge sys_clk) begin
    if (accept) begin
      base_q  <= base_word;
      count_q <= word_count;
    end
  end

  assign scan.go    = go_q;
  assign scan.base  = base_q;
  assign scan.count = count_q;

  // Status
  assign sum_clear = accept;
  assign busy      = (state_q != SCAN_IDLE);
  assign done      = (state_q == SCAN_DONE);

endmodule

/* word_checksum.sv */
// ------------------------------
// Word checksum
// ------------------------------
`include "fbuf_params.svh"

module word_checksum import fbuf_pkg::*; (
  input  logic  sys_clk,
  input  logic  reset,
  // Start of a new scan
  input  logic  sum_clear,
  // Streamed words
  input  logic  out_valid,
  input  word_t out_word,
  output word_t checksum
);

  // Running sum, carry out dropped
  logic [`FBUF_WORD_W-1:0] sum_q;

  // ------------------------------
  // Accumulator
  // ------------------------------
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      sum_q <= '0;
    end else if (sum_clear) begin
      sum_q <= '0;
    end else if (out_valid) begin
      // Modulo 65536 by width
      sum_q <= sum_q + out_word;
    end
  end

  // Holds once the stream ends
  assign checksum = sum_q;

endmodule

/* word_streamer.sv */
// ------------------------------
// Word read streamer
// ------------------------------
`include "fbuf_params.svh"

module word_streamer import fbuf_pkg::*; (
  input  logic       sys_clk,
  input  logic       reset,
  scan_if.stream     scan,
  // RAM port B
  output logic       en_b,
  output word_addr_t addr_b,
  input  word_t      q_b,
  // Word stream
  output logic       out_valid,
  output word_t      out_word
);

  // Reads after the first one
  logic       issuing;
  word_addr_t addr_q;
  count_t     remain_q;
  logic       first_rd;
  // Bit 0 lines up with q_b, bit 1 with out_word
  logic [1:0] vld_sr;

  // ------------------------------
  // Address generator
  // ------------------------------
  // First read leaves in the go cycle itself
  assign first_rd = scan.go && (scan.count != '0);
  assign en_b     = first_rd || issuing;
  assign addr_b   = scan.go ? scan.base : addr_q;

  // Last read of the burst
  assign scan.issue_end = scan.go ? (scan.count == count_t'(1))
                                  : (issuing && remain_q == count_t'(1));

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      issuing  <= 1'b0;
      remain_q <= '0;
    end else if (scan.go) begin
      remain_q <= scan.count - count_t'(1);
      issuing  <= (scan.count > count_t'(1));
    end else if (issuing) begin
      remain_q <= remain_q - count_t'(1);
      issuing  <= (remain_q != count_t'(1));
    end
  end

  // Address wraps modulo 512 by width
  always_ff @(posedge sys_clk) begin
    if (en_b) begin
      addr_q <= addr_b + word_addr_t'(1);
    end
  end

  // ------------------------------
  // Read pipeline
  // ------------------------------
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[0], en_b};
    end
  end

  // Output register for the RAM data
  always_ff @(posedge sys_clk) begin
    if (vld_sr[0]) begin
      out_word <= q_b;
    end
  end

  assign out_valid = vld_sr[1];

  // Nothing issued and nothing waiting on the RAM
  assign scan.idle = !en_b && !vld_sr[0];

endmodule

/* byte_loader.sv */
// ------------------------------
// Byte loader
// ------------------------------
`include "fbuf_params.svh"

module byte_loader import fbuf_pkg::*; (
  input  logic                    sys_clk,
  input  logic                    reset,
  input  logic                    byte_valid,
  input  logic [`FBUF_BYTE_W-1:0] byte_data,
  input  logic                    load_clear,
  // RAM port A
  output logic                    we_a,
  output byte_addr_t              addr_a,
  output logic [`FBUF_BYTE_W-1:0] data_a,
  // Fill status
  output count_t                  bytes_loaded,
  output logic                    full
);

  byte_addr_t ptr_q;
  count_t     fill_q;

  // Full once every byte has been written
  assign full = (fill_q == count_t'(`FBUF_BYTE_DEPTH));

  // Write straight at the pointer, dropped when full or clearing
  assign we_a   = byte_valid && !full && !load_clear;
  assign addr_a = ptr_q;
  assign data_a = byte_data;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      ptr_q  <= '0;
      fill_q <= '0;
    end else if (load_clear) begin
      // Clear wins over a byte in the same cycle
      ptr_q  <= '0;
      fill_q <= '0;
    end else if (we_a) begin
      ptr_q  <= ptr_q + byte_addr_t'(1);
      fill_q <= fill_q + count_t'(1);
    end
  end

  assign bytes_loaded = fill_q;

endmodule

/* dpram_s8_s16.sv */
// ------------------------------
// Dual-port RAM, 8-bit / 16-bit
// ------------------------------
`include "fbuf_params.svh"

module dpram_s8_s16 import fbuf_pkg::*; (
  input  logic                    sys_clk,
  // Port A, byte wide
  input  logic                    we_a,
  input  byte_addr_t              addr_a,
  input  logic [`FBUF_BYTE_W-1:0] data_a,
  output logic [`FBUF_BYTE_W-1:0] q_a,
  // Port B, word wide, read only
  input  logic                    en_b,
  input  word_addr_t              addr_b,
  output word_t                   q_b
);

  // Each bank holds half of the byte space
  localparam int BANK_BYTES = `FBUF_BYTE_DEPTH / 2;
  localparam int BANK_WORDS = `FBUF_WORD_DEPTH / 2;
  localparam int A_OFF_W    = $clog2(BANK_BYTES);
  localparam int B_OFF_W    = $clog2(BANK_WORDS);

  // Registered bank select for the output muxes
  logic bank_a_q;
  logic bank_b_q;

  // ------------------------------
  // Banks
  // ------------------------------
  for (genvar b = 0; b < 2; b++) begin : g_bank
    logic [`FBUF_BYTE_W-1:0] mem [BANK_BYTES];
    logic [`FBUF_BYTE_W-1:0] q_a_r;
    word_t                   q_b_r;
    logic                    sel_a;
    logic                    sel_b;
    logic [A_OFF_W-1:0]      a_off;
    logic [B_OFF_W-1:0]      b_off;

    // Top address bit enables one bank only
    assign sel_a = (addr_a[`FBUF_BYTE_AW-1] == 1'(b));
    assign sel_b = (addr_b[`FBUF_WORD_AW-1] == 1'(b));
    assign a_off = addr_a[`FBUF_BYTE_AW-2:0];
    assign b_off = addr_b[`FBUF_WORD_AW-2:0];

    always_ff @(posedge sys_clk) begin
      // Port A, read before write
      if (sel_a) begin
        if (we_a) begin
          mem[a_off] <= data_a;
        end
        q_a_r <= mem[a_off];
      end
      // Port B, odd byte high, even byte low
      if (en_b && sel_b) begin
        q_b_r <= {mem[{b_off, 1'b1}], mem[{b_off, 1'b0}]};
      end
    end
  end

  // ------------------------------
  // Read muxes
  // ------------------------------
  always_ff @(posedge sys_clk) begin
    bank_a_q <= addr_a[`FBUF_BYTE_AW-1];
    // Hold select with the B data when idle
    if (en_b) begin
      bank_b_q <= addr_b[`FBUF_WORD_AW-1];
    end
  end

  assign q_a = bank_a_q ? g_bank[1].q_a_r : g_bank[0].q_a_r;
  assign q_b = bank_b_q ? g_bank[1].q_b_r : g_bank[0].q_b_r;

endmodule

/* fbuf_if.sv */
// ------------------------------
// Scan control bus
// ------------------------------
interface scan_if import fbuf_pkg::*; ();

  // Controller to streamer
  // One-cycle start of a read burst
  logic       go;
  // First word address and word count, sampled with go
  word_addr_t base;
  count_t     count;

  // Streamer to controller
  // High in the cycle the last read goes out
  logic       issue_end;
  // No read left in the pipeline
  logic       idle;

  modport ctrl (
    output go,
    output base,
    output count,
    input  issue_end,
    input  idle
  );

  modport stream (
    input  go,
    input  base,
    input  count,
    output issue_end,
    output idle
  );

endinterface

/* fbuf_pkg.sv */
// ------------------------------
// Frame buffer types
// ------------------------------
`include "fbuf_params.svh"

package fbuf_pkg;

  // Addresses on the two RAM ports
  typedef logic [`FBUF_BYTE_AW-1:0] byte_addr_t;
  typedef logic [`FBUF_WORD_AW-1:0] word_addr_t;

  // Data word on the 16-bit side
  typedef logic [`FBUF_WORD_W-1:0] word_t;

  // Fill count and scan length
  typedef logic [`FBUF_CNT_W-1:0] count_t;

  // Scan controller states
  typedef enum logic [1:0] {
    SCAN_IDLE  = 2'd0,
    SCAN_ISSUE = 2'd1,
    SCAN_DRAIN = 2'd2,
    SCAN_DONE  = 2'd3
  } scan_state_e;

endpackage

/* fbuf_params.svh */
// ------------------------------
// Frame buffer sizes
// ------------------------------
`ifndef FBUF_PARAMS_SVH
`define FBUF_PARAMS_SVH

// Byte side of the RAM
`define FBUF_BYTE_W      8
`define FBUF_BYTE_AW     10
`define FBUF_BYTE_DEPTH  1024

// Word side, two bytes per word
`define FBUF_WORD_W      16
`define FBUF_WORD_AW     9
`define FBUF_WORD_DEPTH  512

// Fill and word counts, wide enough for 1024
`define FBUF_CNT_W       11

`endif
